//--- logic/radio_regs_pkg.sv
`default_nettype none

package radio_regs_pkg;

   ////////////////////////////////////////////////////////////////////
   // Settings bus
   typedef logic [7:0] set_addr_t;

   typedef struct packed {
      logic        stb;
      set_addr_t   addr;
      logic [31:0] data;
   } set_bus_t;

   localparam set_addr_t SR_MISC      = 8'd0;            // 7 regs
   localparam set_addr_t SR_CLK_CTRL  = SR_MISC + 8'd0;
   localparam set_addr_t SR_SERDES    = SR_MISC + 8'd1;
   localparam set_addr_t SR_ADC       = SR_MISC + 8'd2;
   localparam set_addr_t SR_LED_SW    = SR_MISC + 8'd3;
   localparam set_addr_t SR_PHY_RST   = SR_MISC + 8'd4;
   localparam set_addr_t SR_LED_SRC   = SR_MISC + 8'd6;

   localparam set_addr_t SR_TIME64    = 8'd10;           // 3 regs
   localparam set_addr_t SR_TIME_HI   = SR_TIME64 + 8'd0;
   localparam set_addr_t SR_TIME_LO   = SR_TIME64 + 8'd1; // Commits the load
   localparam set_addr_t SR_TIME_MODE = SR_TIME64 + 8'd2; // Bit 0 arms for next PPS

   ////////////////////////////////////////////////////////////////////
   // Readback word map of 16 words
   localparam logic [3:0] RB_COMPAT  = 4'd0;
   localparam logic [3:0] RB_TIME_HI = 4'd1;
   localparam logic [3:0] RB_TIME_LO = 4'd2;
   localparam logic [3:0] RB_PPS_HI  = 4'd3;
   localparam logic [3:0] RB_PPS_LO  = 4'd4;
   localparam logic [3:0] RB_STATUS  = 4'd5;
   localparam logic [3:0] RB_LEDS    = 4'd6;

   // Bump when the register map changes
   localparam logic [31:0] COMPAT_NUM    = {16'd10, 16'd0}; // Major, minor
   localparam logic [31:0] RB_UNUSED     = 32'hFFFF_FFFF;
   localparam logic [7:0]  LED_SRC_RESET = 8'h1E;

   ////////////////////////////////////////////////////////////////////
   // Board control groups
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   // Low bits of the status readback word
   typedef struct packed {
      logic button;
      logic clk_status;
      logic good_sync;
      logic rx_active;
      logic tx_active;
   } status_t;

endpackage

`default_nettype wire

//--- logic/axil_pkg.sv
`default_nettype none

package axil_pkg;

   localparam int AXIL_AW = 12; // Byte address

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axil_resp_e;

   // Master to slave
   typedef struct packed {
      logic               awvalid;
      logic [AXIL_AW-1:0] awaddr;
      logic               wvalid;
      logic [31:0]        wdata;
      logic [3:0]         wstrb;
      logic               bready;
      logic               arvalid;
      logic [AXIL_AW-1:0] araddr;
      logic               rready;
   } axil_req_t;

   // Slave to master
   typedef struct packed {
      logic        awready;
      logic        wready;
      logic        bvalid;
      axil_resp_e  bresp;
      logic        arready;
      logic        rvalid;
      logic [31:0] rdata;
      axil_resp_e  rresp;
   } axil_rsp_t;

   typedef enum logic [1:0] {
      IDLE,
      WRITE_RESP,
      READ_WAIT,   // Readback mux registers the word
      READ_RESP
   } host_state_e;

endpackage

`default_nettype wire

//--- logic/host_axil_slave.sv
`timescale 1ns/1ps
`default_nettype none

module host_axil_slave (
   input  wire                            dsp_clk,
   input  wire                            por_rst,
   input  wire axil_pkg::axil_req_t       axil_req_i,
   output axil_pkg::axil_rsp_t            axil_rsp_o,
   output radio_regs_pkg::set_bus_t       set_bus_o,
   output logic                           rb_req_o,
   output logic [3:0]                     rb_index_o,
   input  wire  [31:0]                    rb_data_i
);

   import axil_pkg::*;
   import radio_regs_pkg::*;

   host_state_e state_q;

   logic        wr_accept;
   logic        rd_accept;
   logic        wr_ok;
   logic        rd_ok;

   logic        set_stb_q;
   set_addr_t   set_addr_q;
   logic [31:0] set_data_q;
   logic        rb_req_q;
   logic [3:0]  rb_index_q;
   axil_resp_e  bresp_q;
   axil_resp_e  rresp_q;

   ////////////////////////////////////////////////////////////////////
   // Address phase
   // AW and W are taken together and a write wins over a read
   assign wr_accept = (state_q == IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
   assign rd_accept = (state_q == IDLE) && !axil_req_i.awvalid && !axil_req_i.wvalid &&
                      axil_req_i.arvalid;

   assign wr_ok = (axil_req_i.wstrb == 4'hF) && (axil_req_i.awaddr[AXIL_AW-1:10] == '0);
   assign rd_ok = (axil_req_i.araddr[AXIL_AW-1:6] == '0); // Only 16 words decoded

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state_q   <= IDLE;
         set_stb_q <= 1'b0;
         rb_req_q  <= 1'b0;
      end else begin
         set_stb_q <= 1'b0; // Single cycle strobes
         rb_req_q  <= 1'b0;
         case (state_q)
            IDLE: begin
               if (wr_accept) begin
                  state_q   <= WRITE_RESP;
                  set_stb_q <= wr_ok;
               end else if (rd_accept) begin
                  state_q  <= READ_WAIT;
                  rb_req_q <= rd_ok;
               end
            end
            WRITE_RESP: begin
               if (axil_req_i.bready) state_q <= IDLE;
            end
            READ_WAIT: state_q <= READ_RESP;
            READ_RESP: begin
               if (axil_req_i.rready) state_q <= IDLE;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Transfer payload held until the response is taken
   always_ff @(posedge dsp_clk) begin
      if (wr_accept) begin
         set_addr_q <= axil_req_i.awaddr[9:2];
         set_data_q <= axil_req_i.wdata;
         bresp_q    <= wr_ok ? OKAY : SLVERR;
      end
      if (rd_accept) begin
         rb_index_q <= axil_req_i.araddr[5:2];
         rresp_q    <= rd_ok ? OKAY : SLVERR;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Response phase
   always_comb begin
      axil_rsp_o.awready = wr_accept;
      axil_rsp_o.wready  = wr_accept;
      axil_rsp_o.bvalid  = (state_q == WRITE_RESP);
      axil_rsp_o.bresp   = bresp_q;
      axil_rsp_o.arready = (state_q == IDLE) && !axil_req_i.awvalid && !axil_req_i.wvalid;
      axil_rsp_o.rvalid  = (state_q == READ_RESP);
      axil_rsp_o.rdata   = (rresp_q == SLVERR) ? RB_UNUSED : rb_data_i; // Mux holds its word
      axil_rsp_o.rresp   = rresp_q;
   end

   assign set_bus_o  = '{stb: set_stb_q, addr: set_addr_q, data: set_data_q};
   assign rb_req_o   = rb_req_q;
   assign rb_index_o = rb_index_q;

endmodule

`default_nettype wire

//--- logic/misc_control.sv
`timescale 1ns/1ps
`default_nettype none

module misc_control (
   input  wire                               dsp_clk,
   input  wire                               por_rst,
   input  wire radio_regs_pkg::set_bus_t     set_bus_i,
   input  wire radio_regs_pkg::status_t      status_i,
   output radio_regs_pkg::clock_ctrl_t       clock_ctrl_o,
   output radio_regs_pkg::serdes_ctrl_t      serdes_ctrl_o,
   output radio_regs_pkg::adc_ctrl_t         adc_ctrl_o,
   output logic                              phy_reset_n_o,
   output logic [7:0]                        leds_o
);

   import radio_regs_pkg::*;

   clock_ctrl_t  clock_ctrl_q;
   serdes_ctrl_t serdes_ctrl_q;
   adc_ctrl_t    adc_ctrl_q;
   logic         phy_reset_q;
   logic [7:0]   led_sw_q;
   logic [7:0]   led_src_q;     // 1 selects hardware, 0 software
   logic [7:0]   led_hw;
   logic [7:0]   leds_q;

   ////////////////////////////////////////////////////////////////////
   // Setting registers
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clock_ctrl_q  <= '0;
         serdes_ctrl_q <= '0;
         adc_ctrl_q    <= '0;
         phy_reset_q   <= 1'b0;
         led_sw_q      <= '0;
         led_src_q     <= LED_SRC_RESET;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            SR_CLK_CTRL: clock_ctrl_q  <= clock_ctrl_t'(set_bus_i.data[4:0]);
            SR_SERDES:   serdes_ctrl_q <= serdes_ctrl_t'(set_bus_i.data[3:0]);
            SR_ADC:      adc_ctrl_q    <= adc_ctrl_t'(set_bus_i.data[3:0]);
            SR_LED_SW:   led_sw_q      <= set_bus_i.data[7:0];
            SR_PHY_RST:  phy_reset_q   <= set_bus_i.data[0];
            SR_LED_SRC:  led_src_q     <= set_bus_i.data[7:0];
            default: ;                 // Not ours
         endcase
      end
   end

   assign clock_ctrl_o  = clock_ctrl_q;
   assign serdes_ctrl_o = serdes_ctrl_q;
   assign adc_ctrl_o    = adc_ctrl_q;
   assign phy_reset_n_o = ~phy_reset_q; // PHY reset pin is active low

   ////////////////////////////////////////////////////////////////////
   // LEDs
   assign led_hw = {3'b000, status_i.tx_active, status_i.rx_active,
                    status_i.clk_status, status_i.good_sync, 1'b0};

   always_ff @(posedge dsp_clk) begin
      if (por_rst) leds_q <= '0;
      else         leds_q <= (led_src_q & led_hw) | (~led_src_q & led_sw_q);
   end

   assign leds_o = leds_q;

endmodule

`default_nettype wire

//--- logic/vita_time_core.sv
`timescale 1ns/1ps
`default_nettype none

module vita_time_core (
   input  wire                            dsp_clk,
   input  wire                            por_rst,
   input  wire radio_regs_pkg::set_bus_t  set_bus_i,
   input  wire                            pps_i,
   output logic [63:0]                    vita_time_o,
   output logic [63:0]                    vita_time_pps_o,
   output logic                           good_sync_o
);

   import radio_regs_pkg::*;

   logic [31:0] time_hi_q;       // Pending high word
   logic        mode_q;
   logic        armed_q;
   logic [63:0] armed_time_q;
   logic [63:0] time_q;
   logic [63:0] time_pps_q;
   logic        good_sync_q;
   logic [2:0]  pps_sync_q;
   logic        pps_edge;
   logic        hit_lo;
   logic        load_now;
   logic        arm_load;

   assign hit_lo   = set_bus_i.stb && (set_bus_i.addr == SR_TIME_LO);
   assign load_now = hit_lo && !mode_q;
   assign arm_load = hit_lo && mode_q;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_hi_q <= '0;
         mode_q    <= 1'b0;
      end else if (set_bus_i.stb) begin
         if (set_bus_i.addr == SR_TIME_HI)   time_hi_q <= set_bus_i.data;
         if (set_bus_i.addr == SR_TIME_MODE) mode_q    <= set_bus_i.data[0];
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (arm_load) armed_time_q <= {time_hi_q, set_bus_i.data};
   end

   ////////////////////////////////////////////////////////////////////
   // Two flop PPS sync and rising edge detect
   always_ff @(posedge dsp_clk) begin
      if (por_rst) pps_sync_q <= '0;
      else         pps_sync_q <= {pps_sync_q[1:0], pps_i};
   end

   assign pps_edge = pps_sync_q[1] & ~pps_sync_q[2];

   ////////////////////////////////////////////////////////////////////
   // Counter and PPS latch
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_q      <= '0;
         time_pps_q  <= '0;
         armed_q     <= 1'b0;
         good_sync_q <= 1'b0;
      end else begin
         if (load_now)                  time_q <= {time_hi_q, set_bus_i.data};
         else if (pps_edge && armed_q)  time_q <= armed_time_q;
         else                           time_q <= time_q + 64'd1;

         if (pps_edge) begin
            time_pps_q <= armed_q ? armed_time_q : time_q;
            if (armed_q) good_sync_q <= 1'b1; // Sticky until reset
         end

         if (arm_load)                  armed_q <= 1'b1;
         else if (pps_edge)             armed_q <= 1'b0;
      end
   end

   assign vita_time_o     = time_q;
   assign vita_time_pps_o = time_pps_q;
   assign good_sync_o     = good_sync_q;

endmodule

`default_nettype wire

//--- logic/readback_mux.sv
`timescale 1ns/1ps
`default_nettype none

module readback_mux (
   input  wire                            dsp_clk,
   input  wire                            por_rst,
   input  wire                            rb_req_i,
   input  wire  [3:0]                     rb_index_i,
   input  wire  [63:0]                    vita_time_i,
   input  wire  [63:0]                    vita_time_pps_i,
   input  wire radio_regs_pkg::status_t   status_i,
   input  wire  [7:0]                     leds_i,
   output logic [31:0]                    rb_data_o
);

   import radio_regs_pkg::*;

   logic        req_seen_q;     // Any word selected since reset
   logic [31:0] rb_data_q;
   logic [31:0] time_lo_snap_q; // Low half taken with the high half

   always_ff @(posedge dsp_clk) begin
      if (por_rst)       req_seen_q <= 1'b0;
      else if (rb_req_i) req_seen_q <= 1'b1;
   end

   always_ff @(posedge dsp_clk) begin
      if (rb_req_i) begin
         case (rb_index_i)
            RB_COMPAT:  rb_data_q <= COMPAT_NUM;
            RB_TIME_HI: begin
               rb_data_q      <= vita_time_i[63:32];
               time_lo_snap_q <= vita_time_i[31:0];
            end
            RB_TIME_LO: rb_data_q <= time_lo_snap_q;
            RB_PPS_HI:  rb_data_q <= vita_time_pps_i[63:32];
            RB_PPS_LO:  rb_data_q <= vita_time_pps_i[31:0];
            RB_STATUS:  rb_data_q <= {27'd0, status_i};
            RB_LEDS:    rb_data_q <= {24'd0, leds_i};
            default:    rb_data_q <= RB_UNUSED;
         endcase
      end
   end

   // Unused pattern until the first request lands
   assign rb_data_o = req_seen_q ? rb_data_q : RB_UNUSED;

endmodule

`default_nettype wire

//--- logic/radio_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module radio_core_top (
   input  wire                            dsp_clk,
   input  wire                            por_rst,
   // Host port
   input  wire axil_pkg::axil_req_t       axil_req_i,
   output axil_pkg::axil_rsp_t            axil_rsp_o,
   // Board inputs
   input  wire                            pps_i,
   input  wire                            button_i,
   input  wire                            clk_status_i,
   input  wire                            rx_active_i,
   input  wire                            tx_active_i,
   // Board control
   output radio_regs_pkg::clock_ctrl_t    clock_ctrl_o,
   output radio_regs_pkg::serdes_ctrl_t   serdes_ctrl_o,
   output radio_regs_pkg::adc_ctrl_t      adc_ctrl_o,
   output logic                           phy_reset_n_o,
   output logic [7:0]                     leds_o
);

   import radio_regs_pkg::*;

   set_bus_t    set_bus;
   status_t     status;
   logic        rb_req;
   logic [3:0]  rb_index;
   logic [31:0] rb_data;
   logic [63:0] vita_time;
   logic [63:0] vita_time_pps;
   logic        good_sync;

   assign status = '{button: button_i, clk_status: clk_status_i, good_sync: good_sync,
                     rx_active: rx_active_i, tx_active: tx_active_i};

   ////////////////////////////////////////////////////////////////////
   host_axil_slave u_host (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .axil_req_i(axil_req_i), .axil_rsp_o(axil_rsp_o), .set_bus_o(set_bus),
      .rb_req_o(rb_req), .rb_index_o(rb_index), .rb_data_i(rb_data));

   misc_control u_misc (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_bus_i(set_bus), .status_i(status),
      .clock_ctrl_o(clock_ctrl_o), .serdes_ctrl_o(serdes_ctrl_o), .adc_ctrl_o(adc_ctrl_o),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o));

   vita_time_core u_time (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_bus_i(set_bus), .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps), .good_sync_o(good_sync));

   readback_mux u_rb (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .rb_req_i(rb_req), .rb_index_i(rb_index),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .status_i(status), .leds_i(leds_o), .rb_data_o(rb_data));

endmodule

`default_nettype wire

//--- tb/radio_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module radio_core_checker (
   input  wire                            dsp_clk,
   input  wire                            por_rst,
   input  wire axil_pkg::axil_req_t       axil_req_i,
   input  wire axil_pkg::axil_rsp_t       axil_rsp_i
);

   ////////////////////////////////////////////////////////////////////
   // Response channels hold until taken
   b_hold: assert property (@(posedge dsp_clk) disable iff (por_rst)
      axil_rsp_i.bvalid && !axil_req_i.bready |=>
         axil_rsp_i.bvalid && $stable(axil_rsp_i.bresp))
      else $error("Write response dropped or changed before bready");

   r_hold: assert property (@(posedge dsp_clk) disable iff (por_rst)
      axil_rsp_i.rvalid && !axil_req_i.rready |=>
         axil_rsp_i.rvalid && $stable(axil_rsp_i.rdata) && $stable(axil_rsp_i.rresp))
      else $error("Read response dropped or changed before rready");

   // One transfer in flight
   no_aw_while_b: assert property (@(posedge dsp_clk) disable iff (por_rst)
      !(axil_rsp_i.awready && axil_rsp_i.bvalid))
      else $error("Write address accepted while a write response is pending");

   quiet_after_reset: assert property (@(posedge dsp_clk)
      por_rst |=> !axil_rsp_i.bvalid && !axil_rsp_i.rvalid)
      else $error("Response valid in the cycle after reset");

endmodule

bind host_axil_slave radio_core_checker u_checker (
   .dsp_clk(dsp_clk), .por_rst(por_rst), .axil_req_i(axil_req_i), .axil_rsp_i(axil_rsp_o));

`default_nettype wire

//--- tb/radio_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module radio_core_tb;

   import radio_regs_pkg::*;
   import axil_pkg::*;

   localparam int MAX_CYCLES = 800; // About four times the test length

   logic         dsp_clk = 1'b0;
   logic         por_rst;
   axil_req_t    req;
   axil_rsp_t    rsp;
   logic         pps;
   logic         button;
   logic         clk_status;
   logic         rx_active;
   logic         tx_active;
   clock_ctrl_t  clock_ctrl;
   serdes_ctrl_t serdes_ctrl;
   adc_ctrl_t    adc_ctrl;
   logic         phy_reset_n;
   logic [7:0]   leds;
   logic [31:0]  rand_state;
   logic         exp_good_sync;  // Tracks armed PPS loads
   int           cycles = 0;

   radio_core_top DUT (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .axil_req_i(req), .axil_rsp_o(rsp),
      .pps_i(pps), .button_i(button), .clk_status_i(clk_status),
      .rx_active_i(rx_active), .tx_active_i(tx_active),
      .clock_ctrl_o(clock_ctrl), .serdes_ctrl_o(serdes_ctrl), .adc_ctrl_o(adc_ctrl),
      .phy_reset_n_o(phy_reset_n), .leds_o(leds));

   always #5 dsp_clk = ~dsp_clk;

   always @(posedge dsp_clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
         $display("SIMULATION FAILED");
         $fatal(1, "Run stopped by the cycle limit");
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Helpers
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // x^32+x^22+x^2+x+1
   endfunction

   function automatic logic [31:0] draw_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         bits       = {bits[30:0], rand_state[0]};
         rand_state = lfsr_next(rand_state);
      end
      return bits;
   endfunction

   // Source bit 1 picks the hardware vector
   function automatic logic [7:0] expected_leds(input logic [7:0] sw, input logic [7:0] src,
                                                input logic [3:0] ins, input logic sync);
      logic [7:0] hw;
      logic [7:0] result;
      hw = {3'b000, ins[0], ins[1], ins[2], sync, 1'b0}; // ins is {button, clk, rx, tx}
      for (int i = 0; i < 8; i++) result[i] = src[i] ? hw[i] : sw[i];
      return result;
   endfunction

   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
         $display("SIMULATION FAILED");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int hold, output axil_resp_e resp);
      req.awvalid <= 1'b1;
      req.awaddr  <= addr;
      req.wvalid  <= 1'b1;
      req.wdata   <= data;
      req.wstrb   <= strb;
      @(posedge dsp_clk);
      while (!rsp.awready) @(posedge dsp_clk);
      compare("axil_write_wready", 32'd1, {31'd0, rsp.wready}); // W taken with AW
      req.awvalid <= 1'b0;
      req.wvalid  <= 1'b0;
      repeat (hold) @(posedge dsp_clk);  // Back-pressure on B
      req.bready <= 1'b1;
      @(posedge dsp_clk);
      while (!rsp.bvalid) @(posedge dsp_clk);
      resp = rsp.bresp;
      req.bready <= 1'b0;
   endtask

   task automatic axil_read(input logic [11:0] addr, input int hold,
                            output logic [31:0] data, output axil_resp_e resp);
      req.arvalid <= 1'b1;
      req.araddr  <= addr;
      @(posedge dsp_clk);
      while (!rsp.arready) @(posedge dsp_clk);
      req.arvalid <= 1'b0;
      repeat (hold) @(posedge dsp_clk);
      req.rready <= 1'b1;
      @(posedge dsp_clk);
      while (!rsp.rvalid) @(posedge dsp_clk);
      data = rsp.rdata;
      resp = rsp.rresp;
      req.rready <= 1'b0;
   endtask

   task automatic write_setting(input string name, input set_addr_t sr, input logic [31:0] data);
      axil_resp_e resp;
      axil_write({2'b00, sr, 2'b00}, data, 4'hF, 0, resp);
      compare(name, 32'(OKAY), 32'(resp));
   endtask

   task automatic read_word(input string name, input logic [3:0] idx, output logic [31:0] data);
      axil_resp_e resp;
      axil_read({6'd0, idx, 2'b00}, 0, data, resp);
      compare(name, 32'(OKAY), 32'(resp));
   endtask

   ////////////////////////////////////////////////////////////////////
   // Directed tests
   task automatic reset_state_test();
      logic [31:0] data;
      read_word("compat_resp", RB_COMPAT, data);
      compare("compat", 32'h000A_0000, data);
      compare("reset_clock", 32'd0, {27'd0, clock_ctrl});
      compare("reset_serdes", 32'd0, {28'd0, serdes_ctrl});
      compare("reset_adc", 32'd0, {28'd0, adc_ctrl});
      compare("reset_phy", 32'd1, {31'd0, phy_reset_n});
      compare("reset_leds", {24'd0, expected_leds(8'h00, 8'h1E, 4'hF, 1'b0)}, {24'd0, leds});
   endtask

   task automatic control_writes_test();
      axil_resp_e resp;
      write_setting("wr_clock", SR_MISC + 8'd0, 32'hFFFF_FFF5);
      write_setting("wr_serdes", SR_MISC + 8'd1, 32'h0000_000A);
      write_setting("wr_adc", SR_MISC + 8'd2, 32'h0000_0006);
      write_setting("wr_phy", SR_MISC + 8'd4, 32'h0000_0001);
      @(posedge dsp_clk);
      compare("clock", 32'h15, {27'd0, clock_ctrl});   // Bits 4:0 only
      compare("serdes", 32'hA, {28'd0, serdes_ctrl});
      compare("adc", 32'h6, {28'd0, adc_ctrl});
      compare("phy", 32'd0, {31'd0, phy_reset_n});
      axil_write(12'h000, 32'h0000_000A, 4'h7, 0, resp);
      compare("partial_strb_resp", 32'(SLVERR), 32'(resp));
      axil_write(12'h400, 32'h0000_000A, 4'hF, 0, resp); // Outside the setting space
      compare("range_wr_resp", 32'(SLVERR), 32'(resp));
      @(posedge dsp_clk);
      compare("clock_kept", 32'h15, {27'd0, clock_ctrl});
   endtask

   task automatic led_mux_test();
      logic [7:0]  sw;
      logic [7:0]  src;
      logic [3:0]  ins;
      logic [31:0] data;
      for (int n = 0; n < 8; n++) begin
         sw  = 8'(draw_bits(8));
         src = 8'(draw_bits(8));
         ins = 4'(draw_bits(4));
         {button, clk_status, rx_active, tx_active} <= ins;
         write_setting("wr_led_sw", SR_MISC + 8'd3, {24'd0, sw});
         write_setting("wr_led_src", SR_MISC + 8'd6, {24'd0, src});
         repeat (2) @(posedge dsp_clk);
         compare("leds_port", {24'd0, expected_leds(sw, src, ins, exp_good_sync)}, {24'd0, leds});
         read_word("leds_rb_resp", RB_LEDS, data);
         compare("leds_rb", {24'd0, expected_leds(sw, src, ins, exp_good_sync)}, data);
      end
   endtask

   task automatic time_load_test();
      logic [31:0] data;
      write_setting("wr_mode", SR_TIME64 + 8'd2, 32'd0);
      write_setting("wr_time_hi", SR_TIME64 + 8'd0, 32'd5);
      write_setting("wr_time_lo", SR_TIME64 + 8'd1, 32'd100);
      read_word("time_hi_resp", RB_TIME_HI, data);
      compare("time_hi", 32'd5, data);
      read_word("time_lo_resp", RB_TIME_LO, data);
      compare("time_lo_range", 32'd1, 32'(data >= 32'd100 && data <= 32'd140));
   endtask

   task automatic pps_load_test();
      logic [31:0] data;
      status_t     st;
      write_setting("wr_mode", SR_TIME64 + 8'd2, 32'd1);
      write_setting("wr_time_hi", SR_TIME64 + 8'd0, 32'd7);
      write_setting("wr_time_lo", SR_TIME64 + 8'd1, 32'd0);
      pps <= 1'b1;
      repeat (4) @(posedge dsp_clk);
      pps <= 1'b0;
      repeat (10) @(posedge dsp_clk);
      exp_good_sync = 1'b1;
      read_word("pps_hi_resp", RB_PPS_HI, data);
      compare("pps_hi", 32'd7, data);
      read_word("pps_lo_resp", RB_PPS_LO, data);
      compare("pps_lo", 32'd0, data);
      read_word("status_resp", RB_STATUS, data);
      st = status_t'(data[4:0]);
      compare("good_sync", {31'd0, exp_good_sync}, {31'd0, st.good_sync});
      // Word order is button, clk_status, good_sync, rx_active, tx_active
      compare("status_word",
              {27'd0, button, clk_status, exp_good_sync, rx_active, tx_active}, data);
      read_word("time_hi_resp", RB_TIME_HI, data);
      compare("time_hi_after_pps", 32'd7, data);
   endtask

   task automatic backpressure_test();
      logic [31:0] data;
      logic [3:0]  serdes_val;
      axil_resp_e  resp;
      serdes_val = 4'(draw_bits(4));
      axil_write(12'h004, {28'd0, serdes_val}, 4'hF, int'(draw_bits(4) % 15) + 1, resp);
      compare("bp_write_resp", 32'(OKAY), 32'(resp));
      @(posedge dsp_clk);
      compare("bp_serdes", {28'd0, serdes_val}, {28'd0, serdes_ctrl});
      axil_read(12'h000, int'(draw_bits(4) % 15) + 1, data, resp);
      compare("bp_read_resp", 32'(OKAY), 32'(resp));
      compare("bp_compat", 32'h000A_0000, data);
      axil_read(12'h044, int'(draw_bits(4) % 15) + 1, data, resp); // Bit 6 set
      compare("range_rd_resp", 32'(SLVERR), 32'(resp));
      compare("range_rd_data", 32'hFFFF_FFFF, data);
      axil_read(12'h024, 0, data, resp);
      compare("unused_resp", 32'(OKAY), 32'(resp));
      compare("unused_data", 32'hFFFF_FFFF, data);
   endtask

   initial begin
      por_rst       = 1'b1;
      req           = '0;
      pps           = 1'b0;
      button        = 1'b1;
      clk_status    = 1'b1;
      rx_active     = 1'b1;
      tx_active     = 1'b1;
      rand_state    = 32'h82a1_44c5;
      exp_good_sync = 1'b0;
      repeat (8) @(posedge dsp_clk);
      por_rst <= 1'b0;
      @(posedge dsp_clk);
      reset_state_test();
      control_writes_test();
      led_mux_test();
      time_load_test();
      pps_load_test();
      backpressure_test();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
logic/radio_regs_pkg.sv
logic/axil_pkg.sv
logic/host_axil_slave.sv
logic/misc_control.sv
logic/vita_time_core.sv
logic/readback_mux.sv
logic/radio_core_top.sv
tb/radio_core_checker.sv
tb/radio_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the radio core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module radio_core_tb \
   -o radio_core_sim \
   && ./obj_dir/radio_core_sim \
   || exit 1
